//--- include/pet_bus_params.svh
// PET memory bus parameters
// widths, enable divider and the video region window
`ifndef PET_BUS_PARAMS_SVH
`define PET_BUS_PARAMS_SVH

// wishbone word address width
`define PET_ADDR_WIDTH 10

// data bus width
`define PET_DATA_WIDTH 8

// bus clocks per enable pulse, at least 4 so an ack stays within its slot
`define PET_CLK_DIV 8

// video region, in words
`define PET_VIDEO_BASE 0
`define PET_VIDEO_WORDS 16

`endif

//--- list.f
+incdir+include
src/common_pkg.sv
src/enable_timer.sv
src/slot_arbiter.sv
src/video_fetch.sv
src/wb_ram.sv
src/pet_bus_top.sv
tests/tb_pet_bus.sv

//--- run.sh
#!/bin/sh
# build the PET bus testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pet_bus -f list.f -o tb_pet_bus

# the pipeline status is the status of tee, so a failing run still reaches the search
./obj_dir/tb_pet_bus | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "PASS: simulation succeeded"
else
    echo "FAIL: see sim.log"
    exit 1
fi

//--- src/common_pkg.sv
// Shared types for the PET memory bus
// bus vectors, slot number and the video fetcher states
`include "pet_bus_params.svh"

package common_pkg;

    // word address on the shared RAM bus
    typedef logic [`PET_ADDR_WIDTH-1:0] wb_addr_t;

    // one data word
    typedef logic [`PET_DATA_WIDTH-1:0] wb_data_t;

    // position within the eight-slot frame
    typedef logic [2:0] slot_t;

    // video fetcher FSM
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_ACK
    } fetch_state_t;

endpackage

//--- src/enable_timer.sv
// Bus enable timer
// one-cycle enable pulse every PET_CLK_DIV bus clocks
`include "pet_bus_params.svh"

module enable_timer (
    input  logic wb_clock_i,
    input  logic reset_i,
    output logic bus_en_o
);
    localparam int CNT_W = $clog2(`PET_CLK_DIV);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`PET_CLK_DIV - 1);

    logic [CNT_W-1:0] count;

    // pulse is registered, so it lands one clock after the count hits zero
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            count    <= RELOAD;
            bus_en_o <= 1'b0;
        end else if (count == '0) begin
            count    <= RELOAD;
            bus_en_o <= 1'b1;
        end else begin
            count    <= count - 1'b1;
            bus_en_o <= 1'b0;
        end
    end

    // slots depend on a strictly single-cycle pulse
    a_single_pulse: assert property (
        @(posedge wb_clock_i) disable iff (reset_i)
        bus_en_o |=> !bus_en_o
    );

endmodule

//--- src/pet_bus_top.sv
// PET memory bus top level
// shares one RAM between video, CPU slot and host port via fixed time slots
`include "pet_bus_params.svh"

module pet_bus_top
    import common_pkg::*;
(
    input  logic     wb_clock_i,
    input  logic     reset_i,

    input  wb_addr_t host_addr_i,
    input  wb_data_t host_data_i,
    input  logic     host_we_i,
    input  logic     host_cycle_i,
    input  logic     host_strobe_i,
    output logic     host_stall_o,
    output logic     host_ack_o,
    output wb_data_t host_data_o,

    output wb_data_t pixel_o,
    output logic     pixel_valid_o,
    output logic     cpu_grant_en_o
);
    logic     bus_en;

    // shared RAM bus
    wb_addr_t ram_addr;
    wb_data_t ram_wdata;
    wb_data_t ram_rdata;
    logic     ram_we;
    logic     ram_cycle;
    logic     ram_strobe;
    logic     ram_ack;

    // video master
    wb_addr_t video_addr;
    wb_data_t video_rdata;
    logic     video_cycle;
    logic     video_strobe;
    logic     video_stall;
    logic     video_ack;

    enable_timer timer (
        .wb_clock_i (wb_clock_i),
        .reset_i    (reset_i),
        .bus_en_o   (bus_en)
    );

    // video master is read-only, so its write side is tied off
    slot_arbiter arbiter (
        .wb_clock_i     (wb_clock_i),
        .reset_i        (reset_i),
        .bus_en_i       (bus_en),
        .wb_addr_o      (ram_addr),
        .wb_data_o      (ram_wdata),
        .wb_we_o        (ram_we),
        .wb_cycle_o     (ram_cycle),
        .wb_strobe_o    (ram_strobe),
        .wb_ack_i       (ram_ack),
        .wb_data_i      (ram_rdata),
        .host_addr_i    (host_addr_i),
        .host_data_i    (host_data_i),
        .host_we_i      (host_we_i),
        .host_cycle_i   (host_cycle_i),
        .host_strobe_i  (host_strobe_i),
        .host_stall_o   (host_stall_o),
        .host_ack_o     (host_ack_o),
        .host_data_o    (host_data_o),
        .video_addr_i   (video_addr),
        .video_data_i   ('0),
        .video_we_i     (1'b0),
        .video_cycle_i  (video_cycle),
        .video_strobe_i (video_strobe),
        .video_stall_o  (video_stall),
        .video_ack_o    (video_ack),
        .video_data_o   (video_rdata),
        .cpu_grant_en_o (cpu_grant_en_o)
    );

    video_fetch fetch (
        .wb_clock_i    (wb_clock_i),
        .reset_i       (reset_i),
        .wb_addr_o     (video_addr),
        .wb_cycle_o    (video_cycle),
        .wb_strobe_o   (video_strobe),
        .wb_stall_i    (video_stall),
        .wb_ack_i      (video_ack),
        .wb_data_i     (video_rdata),
        .pixel_o       (pixel_o),
        .pixel_valid_o (pixel_valid_o)
    );

    wb_ram ram (
        .wb_clock_i  (wb_clock_i),
        .reset_i     (reset_i),
        .wb_addr_i   (ram_addr),
        .wb_data_i   (ram_wdata),
        .wb_we_i     (ram_we),
        .wb_cycle_i  (ram_cycle),
        .wb_strobe_i (ram_strobe),
        .wb_ack_o    (ram_ack),
        .wb_data_o   (ram_rdata)
    );

endmodule

//--- src/slot_arbiter.sv
// Time-slot arbiter for the shared RAM
// eight slots per frame: four video, two CPU, two host
// the granted master may strobe only in the cycle after an enable pulse
`include "pet_bus_params.svh"

module slot_arbiter
    import common_pkg::*;
(
    input  logic     wb_clock_i,
    input  logic     reset_i,
    input  logic     bus_en_i,

    output wb_addr_t wb_addr_o,
    output wb_data_t wb_data_o,
    output logic     wb_we_o,
    output logic     wb_cycle_o,
    output logic     wb_strobe_o,
    input  logic     wb_ack_i,
    input  wb_data_t wb_data_i,

    input  wb_addr_t host_addr_i,
    input  wb_data_t host_data_i,
    input  logic     host_we_i,
    input  logic     host_cycle_i,
    input  logic     host_strobe_i,
    output logic     host_stall_o,
    output logic     host_ack_o,
    output wb_data_t host_data_o,

    input  wb_addr_t video_addr_i,
    input  wb_data_t video_data_i,
    input  logic     video_we_i,
    input  logic     video_cycle_i,
    input  logic     video_strobe_i,
    output logic     video_stall_o,
    output logic     video_ack_o,
    output wb_data_t video_data_o,

    output logic     cpu_grant_en_o
);
    localparam slot_t LAST_SLOT = 3'd7;
    localparam slot_t CPU_1     = 3'd4;
    localparam slot_t CPU_2     = 3'd5;
    localparam slot_t HOST_1    = 3'd6;
    localparam slot_t HOST_2    = 3'd7;

    slot_t slot;
    logic  strobe_window;
    logic  video_grant;
    logic  cpu_grant;
    logic  host_grant;

    // starts on the last slot so the first pulse opens slot 0
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            slot          <= LAST_SLOT;
            strobe_window <= 1'b0;
        end else begin
            strobe_window <= bus_en_i;
            if (bus_en_i) begin
                slot <= slot + 1'b1;
            end
        end
    end

    // slots 0-3 have a clear top bit
    assign video_grant = !slot[2];
    assign cpu_grant   = (slot == CPU_1) || (slot == CPU_2);
    assign host_grant  = (slot == HOST_1) || (slot == HOST_2);

    always_comb begin
        wb_addr_o     = '0;
        wb_data_o     = '0;
        wb_we_o       = 1'b0;
        wb_cycle_o    = 1'b0;
        wb_strobe_o   = 1'b0;
        host_stall_o  = 1'b1;
        video_stall_o = 1'b1;

        if (host_grant) begin
            wb_addr_o    = host_addr_i;
            wb_data_o    = host_data_i;
            wb_we_o      = host_we_i;
            wb_cycle_o   = host_cycle_i;
            wb_strobe_o  = host_strobe_i & strobe_window;
            host_stall_o = !strobe_window;
        end else if (video_grant) begin
            wb_addr_o     = video_addr_i;
            wb_data_o     = video_data_i;
            wb_we_o       = video_we_i;
            wb_cycle_o    = video_cycle_i;
            wb_strobe_o   = video_strobe_i & strobe_window;
            video_stall_o = !strobe_window;
        end
    end

    // ack arrives one clock after the window, still inside the same slot
    assign host_ack_o   = host_grant & wb_ack_i;
    assign host_data_o  = host_grant ? wb_data_i : '0;
    assign video_ack_o  = video_grant & wb_ack_i;
    assign video_data_o = video_grant ? wb_data_i : '0;

    assign cpu_grant_en_o = cpu_grant & strobe_window;

    a_strobe_after_enable: assert property (
        @(posedge wb_clock_i) disable iff (reset_i)
        wb_strobe_o |-> $past(bus_en_i)
    );

    a_one_owner: assert property (
        @(posedge wb_clock_i) disable iff (reset_i)
        host_stall_o || video_stall_o
    );

endmodule

//--- src/video_fetch.sv
// Video fetcher
// reads the video region in address order, one word per bus transfer,
// and presents each word as a pixel strobe
`include "pet_bus_params.svh"

module video_fetch
    import common_pkg::*;
(
    input  logic     wb_clock_i,
    input  logic     reset_i,

    output wb_addr_t wb_addr_o,
    output logic     wb_cycle_o,
    output logic     wb_strobe_o,
    input  logic     wb_stall_i,
    input  logic     wb_ack_i,
    input  wb_data_t wb_data_i,

    output wb_data_t pixel_o,
    output logic     pixel_valid_o
);
    localparam wb_addr_t FIRST_ADDR = `PET_ADDR_WIDTH'(`PET_VIDEO_BASE);
    localparam wb_addr_t LAST_ADDR  = `PET_ADDR_WIDTH'(`PET_VIDEO_BASE + `PET_VIDEO_WORDS - 1);

    fetch_state_t state;
    wb_addr_t     addr;

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            state         <= IDLE;
            addr          <= FIRST_ADDR;
            pixel_valid_o <= 1'b0;
        end else begin
            pixel_valid_o <= 1'b0;
            case (state)
                IDLE: begin
                    state <= REQUEST;
                end
                REQUEST: begin
                    // accepted once the arbiter drops stall
                    if (!wb_stall_i) begin
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (wb_ack_i) begin
                        pixel_valid_o <= 1'b1;
                        state         <= REQUEST;
                        if (addr == LAST_ADDR) begin
                            addr <= FIRST_ADDR;
                        end else begin
                            addr <= addr + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // pixel word captured with the ack
    always_ff @(posedge wb_clock_i) begin
        if (state == WAIT_ACK && wb_ack_i) begin
            pixel_o <= wb_data_i;
        end
    end

    assign wb_addr_o   = addr;
    assign wb_cycle_o  = (state == REQUEST) || (state == WAIT_ACK);
    assign wb_strobe_o = (state == REQUEST);

    // a stalled request must stay put until accepted
    a_hold_while_stalled: assert property (
        @(posedge wb_clock_i) disable iff (reset_i)
        (wb_strobe_o && wb_stall_i) |=> (wb_strobe_o && $stable(wb_addr_o))
    );

endmodule

//--- src/wb_ram.sv
// Wishbone RAM
// single port, never stalls, acks one clock after each strobe
`include "pet_bus_params.svh"

module wb_ram
    import common_pkg::*;
(
    input  logic     wb_clock_i,
    input  logic     reset_i,
    input  wb_addr_t wb_addr_i,
    input  wb_data_t wb_data_i,
    input  logic     wb_we_i,
    input  logic     wb_cycle_i,
    input  logic     wb_strobe_i,
    output logic     wb_ack_o,
    output wb_data_t wb_data_o
);
    localparam int DEPTH = 2 ** `PET_ADDR_WIDTH;

    wb_data_t mem [DEPTH];
    logic     access;

    assign access = wb_cycle_i & wb_strobe_i;

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    // read returns the old word on a write
    always_ff @(posedge wb_clock_i) begin
        if (access) begin
            if (wb_we_i) begin
                mem[wb_addr_i] <= wb_data_i;
            end
            wb_data_o <= mem[wb_addr_i];
        end
    end

endmodule

//--- tests/tb_pet_bus.sv
// Testbench for the PET memory bus
// random host traffic checked against a memory model, plus slot timing
// and video pixel checks from a cycle count of enable periods
`include "pet_bus_params.svh"

module tb_pet_bus
    import common_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_DIV        = `PET_CLK_DIV;
    localparam int FRAME          = 8 * CLK_DIV;
    localparam int NUM_RANDOM     = 24;
    localparam int NUM_OPS        = `PET_VIDEO_WORDS + 2 * NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 20 * FRAME;
    localparam int MEM_WORDS      = 2 ** `PET_ADDR_WIDTH;
    localparam wb_addr_t V_BASE   = wb_addr_t'(`PET_VIDEO_BASE);
    localparam wb_addr_t V_LAST   = wb_addr_t'(`PET_VIDEO_BASE + `PET_VIDEO_WORDS - 1);

    logic         wb_clock_i;
    logic         reset_i;
    wb_addr_t     host_addr_i;
    wb_data_t     host_data_i;
    logic         host_we_i;
    logic         host_cycle_i;
    logic         host_strobe_i;
    logic         host_stall_o;
    logic         host_ack_o;
    wb_data_t     host_data_o;
    wb_data_t     pixel_o;
    logic         pixel_valid_o;
    logic         cpu_grant_en_o;

    logic [31:0]  lfsr;
    int           cyc;
    int           host_errors;
    int           video_errors;
    int           timing_errors;
    int           first_grant;
    int           pixels_checked;
    wb_data_t     mem_model [MEM_WORDS];
    wb_addr_t     written [$];
    wb_addr_t     exp_vaddr;
    logic         fill_done;
    logic         video_checking;
    logic         host_accept_q;
    fetch_state_t fetch_state;

    pet_bus_top dut (
        .wb_clock_i     (wb_clock_i),
        .reset_i        (reset_i),
        .host_addr_i    (host_addr_i),
        .host_data_i    (host_data_i),
        .host_we_i      (host_we_i),
        .host_cycle_i   (host_cycle_i),
        .host_strobe_i  (host_strobe_i),
        .host_stall_o   (host_stall_o),
        .host_ack_o     (host_ack_o),
        .host_data_o    (host_data_o),
        .pixel_o        (pixel_o),
        .pixel_valid_o  (pixel_valid_o),
        .cpu_grant_en_o (cpu_grant_en_o)
    );

    assign fetch_state = dut.fetch.state;

    always #5 wb_clock_i = ~wb_clock_i;

    // bus clocks since reset fell
    always @(posedge wb_clock_i) begin
        if (reset_i) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_step()};
        end
        return value;
    endfunction

    // strobe window one clock after each enable pulse
    function automatic logic window_at(input int c);
        return (c > CLK_DIV) && (((c - 1) % CLK_DIV) == 0);
    endfunction

    // frame starts on slot 7, so the first pulse opens slot 0
    function automatic int slot_at(input int c);
        if (c <= CLK_DIV) begin
            return 7;
        end
        return ((c - 1) / CLK_DIV - 1) % 8;
    endfunction

    // host request taken by the RAM in this cycle, acked in the next one
    always @(posedge wb_clock_i) begin
        if (reset_i) begin
            host_accept_q <= 1'b0;
        end else begin
            host_accept_q <= host_cycle_i && host_strobe_i && window_at(cyc)
                             && (slot_at(cyc) >= 6);
        end
    end

    task automatic check_idle_outputs();
        assert (!cpu_grant_en_o) else begin
            timing_errors++;
            $display("Mismatch at %0t: cpu_grant_en_o got %b expected 0",
                     $time, cpu_grant_en_o);
        end
        assert (!pixel_valid_o) else begin
            timing_errors++;
            $display("Mismatch at %0t: pixel_valid_o got %b expected 0",
                     $time, pixel_valid_o);
        end
        assert (!host_ack_o) else begin
            timing_errors++;
            $display("Mismatch at %0t: host_ack_o got %b expected 0",
                     $time, host_ack_o);
        end
        assert (host_stall_o) else begin
            timing_errors++;
            $display("Mismatch at %0t: host_stall_o got %b expected 1",
                     $time, host_stall_o);
        end
    endtask

    // random start point, so the time a request waits for its slot varies
    task automatic host_transfer(input logic we, input wb_addr_t addr, input wb_data_t data,
                                 output wb_data_t rdata);
        int   gap;
        logic accepted;
        gap = int'(random_bits(4));
        repeat (gap) @(negedge wb_clock_i);
        host_addr_i   = addr;
        host_data_i   = data;
        host_we_i     = we;
        host_cycle_i  = 1'b1;
        host_strobe_i = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            if (!host_stall_o) begin
                accepted = 1'b1;
                assert (window_at(cyc) && slot_at(cyc) >= 6) else begin
                    host_errors++;
                    $display("At %0t a host request was accepted outside the host slots",
                             $time);
                end
            end
            @(negedge wb_clock_i);
        end
        host_strobe_i = 1'b0;
        rdata = host_data_o;
        if (we) begin
            mem_model[addr] = data;
            written.push_back(addr);
        end
        host_cycle_i = 1'b0;
    endtask

    always @(negedge wb_clock_i) begin : slot_monitor
        int   exp_slot;
        logic exp_window;
        logic exp_grant;
        logic exp_stall;
        if (cyc != 0) begin
            exp_window = window_at(cyc);
            exp_slot   = slot_at(cyc);
            exp_grant  = exp_window && (exp_slot == 4 || exp_slot == 5);
            exp_stall  = !(exp_window && exp_slot >= 6);
            assert (cpu_grant_en_o == exp_grant) else begin
                timing_errors++;
                $display("Mismatch at %0t: cpu_grant_en_o got %b expected %b",
                         $time, cpu_grant_en_o, exp_grant);
            end
            assert (host_stall_o == exp_stall) else begin
                timing_errors++;
                $display("Mismatch at %0t: host_stall_o got %b expected %b",
                         $time, host_stall_o, exp_stall);
            end
            // exactly one ack per accepted host request
            assert (host_ack_o == host_accept_q) else begin
                host_errors++;
                $display("Mismatch at %0t: host_ack_o got %b expected %b",
                         $time, host_ack_o, host_accept_q);
            end
            if (cpu_grant_en_o && first_grant == 0) begin
                first_grant = cyc;
            end
            if (pixel_valid_o) begin
                if (video_checking) begin
                    assert (pixel_o == mem_model[exp_vaddr]) else begin
                        video_errors++;
                        $display("Mismatch at %0t: pixel_o got %h expected %h at word %0d",
                                 $time, pixel_o, mem_model[exp_vaddr], exp_vaddr);
                    end
                    pixels_checked++;
                end
                exp_vaddr = (exp_vaddr == V_LAST) ? V_BASE : exp_vaddr + 1'b1;
                // start checking on a fresh pass once the region holds known data
                if (exp_vaddr == V_BASE && fill_done) begin
                    video_checking = 1'b1;
                end
            end
        end
    end

    always @(posedge wb_clock_i) begin
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with the video fetcher in %s",
                     cyc, fetch_state.name());
            $display("errors: host %0d, video %0d, timing %0d",
                     host_errors, video_errors, timing_errors);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin : stimulus
        int       i;
        int       idx;
        wb_addr_t addr;
        wb_data_t rdata;
        wb_clock_i     = 1'b0;
        reset_i        = 1'b1;
        host_addr_i    = '0;
        host_data_i    = '0;
        host_we_i      = 1'b0;
        host_cycle_i   = 1'b0;
        host_strobe_i  = 1'b0;
        lfsr           = 32'hd3d8_c503;
        exp_vaddr      = V_BASE;
        fill_done      = 1'b0;
        video_checking = 1'b0;
        pixels_checked = 0;
        first_grant    = 0;
        repeat (10) begin
            @(negedge wb_clock_i);
            check_idle_outputs();
        end
        reset_i = 1'b0;
        @(negedge wb_clock_i);
        check_idle_outputs();

        for (i = 0; i < `PET_VIDEO_WORDS; i++) begin
            host_transfer(1'b1, wb_addr_t'(`PET_VIDEO_BASE + i), wb_data_t'(random_bits(8)),
                          rdata);
        end
        fill_done = 1'b1;

        for (i = 0; i < NUM_RANDOM; i++) begin
            addr = wb_addr_t'(random_bits(`PET_ADDR_WIDTH));
            host_transfer(1'b1, addr, wb_data_t'(random_bits(8)), rdata);
        end
        // read back only words with known contents
        for (i = 0; i < NUM_RANDOM; i++) begin
            idx  = int'(random_bits(16)) % written.size();
            addr = written[idx];
            host_transfer(1'b0, addr, '0, rdata);
            assert (rdata == mem_model[addr]) else begin
                host_errors++;
                $display("Mismatch at %0t: host_data_o got %h expected %h at word %0d",
                         $time, rdata, mem_model[addr], addr);
            end
        end

        while (pixels_checked < 2 * `PET_VIDEO_WORDS) begin
            @(negedge wb_clock_i);
        end
        assert (first_grant == 5 * CLK_DIV + 1) else begin
            timing_errors++;
            $display("Mismatch at %0t: first cpu_grant_en_o cycle got %0d expected %0d",
                     $time, first_grant, 5 * CLK_DIV + 1);
        end

        $display("errors: host %0d, video %0d, timing %0d",
                 host_errors, video_errors, timing_errors);
        if (host_errors + video_errors + timing_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
